// File: lc3b_stall.f
+incdir+verification
logic/lc3b_pkg.sv
logic/control_decoder.sv
logic/register_scoreboard.sv
logic/hazard_detection.sv
logic/stage_pipeline.sv
logic/pipeline_control.sv
verification/pipeline_control_tb.sv

// File: verification/pipeline_control_model.svh
`ifndef PIPELINE_CONTROL_MODEL_SVH
`define PIPELINE_CONTROL_MODEL_SVH

lc3b_word    m_ir;	// Decode instruction register.
lc3b_control m_ctrl;	// Decoded control of m_ir.
lc3b_stage   m_ex;
lc3b_stage   m_mem;
lc3b_stage   m_wb;
lc3b_byte    m_valid;	// Register valid bits.
int          m_br_count;
int          advance_count;	// Advancing clocks so far.

logic e_imem_read;
logic e_insert_nop;
logic e_load_start;
logic e_load_end;
logic e_dmem_request;
logic e_hazard;

lc3b_reg exp_dest[$];	// Destinations in issue order.
int      exp_stamp[$];	// advance_count at issue.

int hazard_cycles;
int branch_count;
int freeze_cycles;

// LC-3b register usage, one flag at a time.
function automatic lc3b_control model_decode(input lc3b_word word);
	lc3b_control c;
	c = '0;
	case (word[15:12])
		op_add, op_and:
		begin
			c.uses_sr1 = 1'b1;
			c.uses_sr2 = !word[5];	// Register form only.
			c.uses_dest = 1'b1;
		end
		op_not, op_shf, op_ldb, op_ldr, op_ldi:
		begin
			c.uses_sr1 = 1'b1;
			c.uses_dest = 1'b1;
		end
		op_stb, op_str, op_sti:
			c.uses_sr1 = 1'b1;
		op_jsr:
		begin
			c.uses_sr1 = !word[11];	// JSRR.
			c.uses_dest = 1'b1;
		end
		op_jmp:
			c.uses_sr1 = 1'b1;
		op_lea, op_trap:
			c.uses_dest = 1'b1;
		default:
			c = '0;
	endcase
	c.is_store = (word[15:12] == op_stb) || (word[15:12] == op_str) || (word[15:12] == op_sti);
	c.mem_access = c.is_store || (word[15:12] == op_ldb) || (word[15:12] == op_ldr)
		|| (word[15:12] == op_ldi);
	c.is_branch = (word[15:12] == op_br) && (word[11:9] != 3'b000);
	if (c.uses_dest)
		c.dest = ((word[15:12] == op_jsr) || (word[15:12] == op_trap)) ? 3'd7 : word[11:9];
	return c;
endfunction

task automatic model_reset();
	m_ir = nop_word;
	m_ex = '0;
	m_mem = '0;
	m_wb = '0;
	m_valid = '1;
	m_br_count = 0;
	advance_count = 0;
	hazard_cycles = 0;
	branch_count = 0;
	freeze_cycles = 0;
endtask

// Expected outputs for the current state and inputs.
task automatic model_eval(input logic imem_resp_in, input logic dmem_resp_in);
	m_ctrl = model_decode(m_ir);
	e_hazard = (m_ctrl.uses_sr1 && !m_valid[m_ir[8:6]])
		|| (m_ctrl.uses_sr2 && !m_valid[m_ir[2:0]])
		|| (m_ctrl.is_store && !m_valid[m_ir[11:9]]);
	e_imem_read = !e_hazard;
	e_dmem_request = m_mem.valid && m_mem.ctrl.mem_access;
	e_insert_nop = e_hazard || (e_imem_read && !imem_resp_in) || (m_br_count != 0);
	e_load_end = !(e_dmem_request && !dmem_resp_in);
	e_load_start = e_load_end && !e_insert_nop;
endtask

// State update on the rising edge.
task automatic model_clock(input lc3b_word fetched);
	logic issuing;
	if (e_hazard)
		hazard_cycles++;
	if (!e_load_end)
	begin
		freeze_cycles++;	// Everything holds.
		return;
	end
	issuing = !e_insert_nop;
	if (m_wb.valid && m_wb.ctrl.uses_dest)
		m_valid[m_wb.ctrl.dest] = 1'b1;
	if (issuing && m_ctrl.uses_dest)
	begin
		m_valid[m_ctrl.dest] = 1'b0;	// Applied after retire.
		exp_dest.push_back(m_ctrl.dest);
		exp_stamp.push_back(advance_count);
	end
	if (m_br_count == BRANCH_SHADOW)
		m_br_count = 0;
	else if (m_br_count != 0)
		m_br_count++;
	else if (issuing && m_ctrl.is_branch)
	begin
		m_br_count = 1;
		branch_count++;
	end
	m_wb = m_mem;
	m_mem = m_ex;
	if (issuing)
	begin
		m_ex.valid = 1'b1;
		m_ex.ctrl = m_ctrl;
	end
	else
		m_ex = '0;
	if (e_load_start)
		m_ir = fetched;
	advance_count++;
endtask

`endif

// File: verification/pipeline_control_tb.sv
`timescale 1ns/10ps

module pipeline_control_tb;
	import lc3b_pkg::*;

	localparam int BRANCH_SHADOW = 3;
	localparam int RANDOM_CYCLES = 800;
	localparam int DRAIN_LIMIT = 200;

	logic     clk;
	logic     rst_n;
	logic     imem_read;
	logic     imem_resp;
	lc3b_word imem_rdata;
	logic     dmem_request;
	logic     dmem_resp;
	logic     load_pc;
	logic     load_de;
	logic     load_ex;
	logic     load_mem;
	logic     load_wb;
	logic     insert_nop;
	logic     wb_valid;
	lc3b_reg  wb_dest;

	logic [31:0] lfsr;
	int value_errors;
	int other_errors;

	`include "pipeline_control_model.svh"

	pipeline_control #(.BRANCH_SHADOW(BRANCH_SHADOW)) DUT
	(
		.clk(clk), .rst_n(rst_n), .imem_read(imem_read), .imem_resp(imem_resp),
		.imem_rdata(imem_rdata), .dmem_request(dmem_request), .dmem_resp(dmem_resp),
		.load_pc(load_pc), .load_de(load_de), .load_ex(load_ex), .load_mem(load_mem),
		.load_wb(load_wb), .insert_nop(insert_nop), .wb_valid(wb_valid), .wb_dest(wb_dest)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Taps 32, 22, 2, 1; one step per bit.
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		logic feedback;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	function automatic lc3b_word random_instruction();
		logic [3:0] opcode;
		logic [11:0] fields;
		case (3'(take_bits(3)))
			3'd0, 3'd1: opcode = op_add;
			3'd2: opcode = op_ldr;
			3'd3: opcode = op_str;
			3'd4: opcode = op_br;
			default: opcode = 4'(take_bits(4));	// Any opcode.
		endcase
		fields = 12'(take_bits(12));
		return {opcode, fields};
	endfunction

	function automatic logic random_resp();
		return (2'(take_bits(2)) != 2'b00);	// Low one time in four.
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input lc3b_pkg::lc3b_reg got,
		input lc3b_pkg::lc3b_reg exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("error at %0t: %s got R%0d expected R%0d", $time, name, got, exp);
		end
	endtask

	task automatic check_after_reset();
		check_bit("insert_nop", insert_nop, 1'b0);
		check_bit("dmem_request", dmem_request, 1'b0);
		check_bit("wb_valid", wb_valid, 1'b0);
		check_bit("imem_read", imem_read, 1'b1);
		check_bit("load_pc", load_pc, 1'b1);
		check_bit("load_de", load_de, 1'b1);
		check_bit("load_ex", load_ex, 1'b1);
		check_bit("load_mem", load_mem, 1'b1);
		check_bit("load_wb", load_wb, 1'b1);
	endtask

	task automatic compare_outputs();
		check_bit("imem_read", imem_read, e_imem_read);
		check_bit("insert_nop", insert_nop, e_insert_nop);
		check_bit("load_pc", load_pc, e_load_start);
		check_bit("load_de", load_de, e_load_start);
		check_bit("load_ex", load_ex, e_load_end);
		check_bit("load_mem", load_mem, e_load_end);
		check_bit("load_wb", load_wb, e_load_end);
		check_bit("dmem_request", dmem_request, e_dmem_request);
		check_bit("wb_valid", wb_valid, m_wb.valid);
		check_reg("wb_dest", wb_dest, m_wb.ctrl.dest);
	endtask

	// Retiring destination against issue order and its three-cycle latency.
	task automatic check_retire();
		int latency;
		if (e_load_end && m_wb.valid && m_wb.ctrl.uses_dest)
		begin
			if (exp_dest.size() == 0)
			begin
				other_errors++;
				$display("Writeback retired R%0d with no issued instruction pending", wb_dest);
			end
			else
			begin
				check_reg("wb_dest", wb_dest, exp_dest.pop_front());
				latency = advance_count - exp_stamp.pop_front();
				if (latency != 3)
				begin
					other_errors++;
					$display("Instruction reached writeback after %0d advancing cycles", latency);
				end
			end
		end
	endtask

	// Starts and ends on a falling edge.
	task automatic run_cycle(input logic random_inputs);
		if (random_inputs)
		begin
			imem_rdata = random_instruction();
			imem_resp = random_resp();
			dmem_resp = random_resp();
		end
		else
		begin
			imem_rdata = nop_word;
			imem_resp = 1'b1;
			dmem_resp = 1'b1;
		end
		#5;
		model_eval(imem_resp, dmem_resp);
		compare_outputs();
		check_retire();
		@(posedge clk);
		model_clock(imem_rdata);
		@(negedge clk);
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (exp_dest.size() != 0 && cycles < DRAIN_LIMIT)
		begin
			run_cycle(1'b0);
			cycles++;
		end
		if (exp_dest.size() != 0)
		begin
			other_errors++;
			$display("Timeout: %0d issued instructions never reached writeback", exp_dest.size());
		end
	endtask

	task automatic check_stimulus();
		if (hazard_cycles == 0 || branch_count == 0 || freeze_cycles == 0)
		begin
			other_errors++;
			$display("Stimulus missed a case: %0d hazard cycles, %0d branches, %0d freezes",
				hazard_cycles, branch_count, freeze_cycles);
		end
	endtask

	initial
	begin
		lfsr = 32'hb8e9a6d5;
		value_errors = 0;
		other_errors = 0;
		rst_n = 1'b0;
		imem_resp = 1'b1;
		dmem_resp = 1'b1;
		imem_rdata = nop_word;
		model_reset();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_after_reset();	// State settled at the last rising edge.
		for (int n = 0; n < RANDOM_CYCLES; n++)
			run_cycle(1'b1);
		wait_for_drain();
		check_stimulus();
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule : pipeline_control_tb

// File: logic/pipeline_control.sv
`timescale 1ns/10ps

module pipeline_control
#(
	parameter int BRANCH_SHADOW = 3
)
(
	input  logic               clk,
	input  logic               rst_n,
	output logic               imem_read,
	input  logic               imem_resp,
	input  lc3b_pkg::lc3b_word imem_rdata,
	output logic               dmem_request,
	input  logic               dmem_resp,
	output logic               load_pc,
	output logic               load_de,
	output logic               load_ex,
	output logic               load_mem,
	output logic               load_wb,
	output logic               insert_nop,
	output logic               wb_valid,
	output lc3b_pkg::lc3b_reg  wb_dest
);
	import lc3b_pkg::*;

	lc3b_word    decode_ir;
	lc3b_control decode_ctrl;
	lc3b_byte    reg_valid;
	lc3b_stage   mem_stage;
	lc3b_stage   wb_stage;
	logic        issue;
	logic        retire;

	assign dmem_request = mem_stage.valid & mem_stage.ctrl.mem_access;
	assign retire = wb_stage.valid & wb_stage.ctrl.uses_dest & load_wb;	// Frozen on data miss.
	assign wb_valid = wb_stage.valid;
	assign wb_dest = wb_stage.ctrl.dest;

	control_decoder decoder
	(
		.ir   (decode_ir),
		.ctrl (decode_ctrl)
	);

	hazard_detection #(.BRANCH_SHADOW(BRANCH_SHADOW)) hazards
	(
		.clk(clk), .rst_n(rst_n), .ir(decode_ir), .ctrl(decode_ctrl), .reg_valid(reg_valid),
		.imem_resp(imem_resp), .dmem_request(dmem_request), .dmem_resp(dmem_resp),
		.imem_read(imem_read), .load_pc(load_pc), .load_de(load_de), .load_ex(load_ex),
		.load_mem(load_mem), .load_wb(load_wb), .insert_nop(insert_nop), .issue(issue)
	);

	register_scoreboard scoreboard
	(
		.clk(clk), .rst_n(rst_n), .issue(issue), .issue_index(decode_ctrl.dest),
		.retire(retire), .retire_index(wb_stage.ctrl.dest), .reg_valid(reg_valid)
	);

	stage_pipeline stages
	(
		.clk(clk), .rst_n(rst_n), .fetch_word(imem_rdata), .load_de(load_de),
		.load_ex(load_ex), .insert_nop(insert_nop), .decode_ir(decode_ir),
		.decode_ctrl(decode_ctrl), .mem_stage(mem_stage), .wb_stage(wb_stage)
	);

endmodule : pipeline_control

// File: logic/stage_pipeline.sv
`timescale 1ns/10ps

module stage_pipeline
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  lc3b_pkg::lc3b_word    fetch_word,
	input  logic                  load_de,
	input  logic                  load_ex,
	input  logic                  insert_nop,
	output lc3b_pkg::lc3b_word    decode_ir,
	input  lc3b_pkg::lc3b_control decode_ctrl,
	output lc3b_pkg::lc3b_stage   mem_stage,
	output lc3b_pkg::lc3b_stage   wb_stage
);
	import lc3b_pkg::*;

	lc3b_word  ir_q;
	lc3b_stage ex_stage;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ir_q <= nop_word;
		else if (load_de)
			ir_q <= fetch_word;	// Held while decode stalls.
	end

	// Execute, memory and writeback advance together on load_ex.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ex_stage <= '0;
			mem_stage <= '0;
			wb_stage <= '0;
		end
		else if (load_ex)
		begin
			if (insert_nop)
				ex_stage <= '0;	// Bubble.
			else
				ex_stage <= '{valid: 1'b1, ctrl: decode_ctrl};
			mem_stage <= ex_stage;
			wb_stage <= mem_stage;
		end
	end

	assign decode_ir = ir_q;

	// Execute and memory come out of reset empty too, so writeback stays empty for three clocks.
	assert property (@(posedge clk)
		!rst_n |=> !wb_stage.valid ##1 !wb_stage.valid ##1 !wb_stage.valid)
	else
		$error("Writeback stage valid too soon after reset");

endmodule : stage_pipeline

// File: logic/hazard_detection.sv
`timescale 1ns/10ps

module hazard_detection
#(
	parameter int BRANCH_SHADOW = 3
)
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  lc3b_pkg::lc3b_word    ir,
	input  lc3b_pkg::lc3b_control ctrl,
	input  lc3b_pkg::lc3b_byte    reg_valid,
	input  logic                  imem_resp,
	input  logic                  dmem_request,
	input  logic                  dmem_resp,
	output logic                  imem_read,
	output logic                  load_pc,
	output logic                  load_de,
	output logic                  load_ex,
	output logic                  load_mem,
	output logic                  load_wb,
	output logic                  insert_nop,
	output logic                  issue
);
	import lc3b_pkg::*;

	localparam int CNT_W = $clog2(BRANCH_SHADOW + 1);

	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_reg store_src;

	logic data_hazard;
	logic imem_miss;
	logic dmem_miss;
	logic load_start;
	logic load_end;
	logic branch_issue;
	logic [CNT_W-1:0] br_count;

	assign sr1 = ir[8:6];
	assign sr2 = ir[2:0];
	assign store_src = ir[11:9];

	// Any source still owned by an instruction that has not retired.
	assign data_hazard = (ctrl.uses_sr1 & ~reg_valid[sr1])
		| (ctrl.uses_sr2 & ~reg_valid[sr2])
		| (ctrl.is_store & ~reg_valid[store_src]);

	assign imem_read = ~data_hazard;	// No point fetching while decode is stuck.
	assign imem_miss = imem_read & ~imem_resp;
	assign dmem_miss = dmem_request & ~dmem_resp;

	assign insert_nop = data_hazard | imem_miss | (br_count != '0);

	assign load_end = ~dmem_miss;	// Data miss freezes everything.
	assign load_start = load_end & ~insert_nop;

	assign load_pc = load_start;
	assign load_de = load_start;
	assign load_ex = load_end;
	assign load_mem = load_end;
	assign load_wb = load_end;

	// Decode instruction moves into execute this clock.
	assign issue = load_ex & ~insert_nop & ctrl.uses_dest;
	assign branch_issue = load_ex & ~insert_nop & ctrl.is_branch;

	// Counts 1..BRANCH_SHADOW after a branch, each value one bubble.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			br_count <= '0;
		else if (load_end)
		begin
			if (br_count == CNT_W'(BRANCH_SHADOW))
				br_count <= '0;	// Shadow done.
			else if (br_count != '0)
				br_count <= br_count + 1'b1;
			else if (branch_issue)
				br_count <= CNT_W'(1);
		end
	end

	// A branch that leaves decode is always followed by a bubble.
	assert property (@(posedge clk) disable iff (!rst_n)
		branch_issue |=> insert_nop)
	else
		$error("No bubble in the cycle after a branch issue");

endmodule : hazard_detection

// File: logic/register_scoreboard.sv
`timescale 1ns/10ps

module register_scoreboard
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue,
	input  lc3b_pkg::lc3b_reg issue_index,
	input  logic              retire,
	input  lc3b_pkg::lc3b_reg retire_index,
	output lc3b_pkg::lc3b_byte reg_valid
);
	import lc3b_pkg::*;

	lc3b_byte valid_q;
	lc3b_byte valid_d;

	// Retire first, then issue, so an issue to the same register wins.
	always_comb
	begin
		valid_d = valid_q;
		if (retire)
			valid_d[retire_index] = 1'b1;	// Producer has written back.
		if (issue)
			valid_d[issue_index] = 1'b0;	// New producer in flight.
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_q <= '1;	// Nothing in flight after reset.
		else
			valid_q <= valid_d;
	end

	assign reg_valid = valid_q;

	// Two writers of one register in flight make the first retire set the bit early.
	assert property (@(posedge clk) disable iff (!rst_n)
		retire |-> !valid_q[retire_index])
	else
		$warning("Retire to R%0d that is already valid", retire_index);

endmodule : register_scoreboard

// File: logic/control_decoder.sv
`timescale 1ns/10ps

module control_decoder
(
	input  lc3b_pkg::lc3b_word    ir,
	output lc3b_pkg::lc3b_control ctrl
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;
	lc3b_reg    dr;

	assign opcode = lc3b_opcode'(ir[15:12]);
	assign dr = ir[11:9];	// DR for ALU ops and loads, SR for stores.

	always_comb
	begin
		ctrl = '0;	// Unlisted fields stay clear.
		unique case (opcode)
			op_br:
			begin
				ctrl.is_branch = (ir[11:9] != 3'b000);	// nzp of zero is the NOP.
			end
			op_add, op_and:
			begin
				ctrl.uses_sr1 = 1'b1;
				ctrl.uses_sr2 = ~ir[5];	// ir[5] selects imm5.
				ctrl.uses_dest = 1'b1;
				ctrl.dest = dr;
			end
			op_not, op_shf:
			begin
				ctrl.uses_sr1 = 1'b1;
				ctrl.uses_dest = 1'b1;
				ctrl.dest = dr;
			end
			op_ldb, op_ldr, op_ldi:
			begin
				ctrl.uses_sr1 = 1'b1;	// Base register.
				ctrl.uses_dest = 1'b1;
				ctrl.mem_access = 1'b1;
				ctrl.dest = dr;
			end
			op_stb, op_str, op_sti:
			begin
				ctrl.uses_sr1 = 1'b1;	// Base register.
				ctrl.is_store = 1'b1;
				ctrl.mem_access = 1'b1;
			end
			op_jsr:
			begin
				ctrl.uses_sr1 = ~ir[11];	// JSRR takes its target from BaseR.
				ctrl.uses_dest = 1'b1;
				ctrl.dest = link_reg;
			end
			op_jmp:
			begin
				ctrl.uses_sr1 = 1'b1;
			end
			op_lea:
			begin
				ctrl.uses_dest = 1'b1;
				ctrl.dest = dr;
			end
			op_trap:
			begin
				ctrl.uses_dest = 1'b1;
				ctrl.dest = link_reg;
			end
			op_rti:
			begin
				ctrl = '0;	// No register traffic tracked.
			end
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

endmodule : control_decoder

// File: logic/lc3b_pkg.sv
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;	// Instruction word.
	typedef logic [2:0] lc3b_reg;	// Register index R0..R7.
	typedef logic [7:0] lc3b_byte;	// One bit per register.

	// LC-3b opcode map, ir[15:12].
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// Per-instruction control that the stall logic needs.
	typedef struct packed
	{
		logic    uses_sr1;	// Reads ir[8:6].
		logic    uses_sr2;	// Reads ir[2:0].
		logic    uses_dest;	// Writes dest at writeback.
		logic    is_store;	// Also reads ir[11:9].
		logic    is_branch;	// Opens the branch shadow.
		logic    mem_access;	// Uses the data port in memory stage.
		lc3b_reg dest;
	} lc3b_control;

	// Contents of the execute, memory and writeback registers.
	typedef struct packed
	{
		logic        valid;
		lc3b_control ctrl;
	} lc3b_stage;

	// BR with n, z and p all clear never branches.
	localparam lc3b_word nop_word = 16'h0000;

	// JSR and TRAP save the return address here.
	localparam lc3b_reg link_reg = 3'd7;

endpackage : lc3b_pkg
